// ==== mips_id.f ====
rtl/mips_isa_pkg.sv
rtl/mips_ctrl_pkg.sv
rtl/id_field_decoder.sv
rtl/id_register_file.sv
rtl/id_branch_unit.sv
rtl/id_control_unit.sv
rtl/id_stage.sv
verif/id_stage_chk.sv
verif/tb_id_stage.sv

// ==== Makefile ====
TOP := tb_id_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f mips_id.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
();

    localparam int PC_W        = 11;
    localparam int HALF_PERIOD = 4;

    typedef struct packed {
        instr_t          instr;
        logic [PC_W-1:0] pc_plus1;
        logic            stall;
        logic            flush;
        wb_t             wb;
        ctrl_t           ctrl;
        logic            taken;
        logic [PC_W-1:0] target;
    } row_t;

    // Fields in order reg_dst, reg_write, alu_src, alu_op, alu_ctrl, mem_read,
    // mem_write, mem_to_reg and link.
    localparam ctrl_t CTRL_NONE = '0;
    localparam ctrl_t CTRL_LW   = '{1'b0, 1'b1, 1'b1, AOP_MEM_ADD, ALU_ADD,
                                    1'b1, 1'b0, 1'b1, 1'b0};
    localparam ctrl_t CTRL_SW   = '{1'b0, 1'b0, 1'b1, AOP_MEM_ADD, ALU_ADD,
                                    1'b0, 1'b1, 1'b0, 1'b0};
    localparam ctrl_t CTRL_JAL  = '{1'b0, 1'b1, 1'b0, AOP_MEM_ADD, ALU_ADD,
                                    1'b0, 1'b0, 1'b0, 1'b1};
    localparam ctrl_t CTRL_JALR = '{1'b1, 1'b1, 1'b0, AOP_MEM_ADD, ALU_ADD,
                                    1'b0, 1'b0, 1'b0, 1'b1};
    localparam wb_t   NO_WB     = '0;

    logic            clock;
    logic            arst_n;
    instr_t          instr;
    logic [PC_W-1:0] pc_plus1;
    wb_t             wb;
    logic            stall;
    logic            flush;
    id_ex_t          id_ex;
    logic            branch_taken;
    logic [PC_W-1:0] branch_target;

    row_t   rows[$];
    word_t  shadow[32];
    id_ex_t exp_q;
    int     errors;
    int     cycles;
    int     cycle_limit;

    id_stage #(
        .PC_W (PC_W)
    ) u_dut (
        .i_clock         (clock),
        .i_arst_n        (arst_n),
        .i_instr         (instr),
        .i_pc_plus1      (pc_plus1),
        .i_wb            (wb),
        .i_stall         (stall),
        .i_flush         (flush),
        .o_id_ex         (id_ex),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    bind id_stage id_stage_chk #(
        .PC_W (PC_W)
    ) u_chk (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_stall         (i_stall),
        .i_flush         (i_flush),
        .i_id_ex         (o_id_ex),
        .i_branch_taken  (o_branch_taken),
        .i_branch_target (o_branch_target)
    );

    initial clock = 1'b0;
    always #HALF_PERIOD clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoders and expected-value model.
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t r_format(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                        shamt_t sh, funct_t fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t i_format(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instr_t j_format(opcode_t op, jidx_t idx);
        return {op, idx};
    endfunction

    function automatic ctrl_t rtype_ctrl(alu_ctrl_e op);
        return '{1'b1, 1'b1, 1'b0, AOP_RTYPE, op, 1'b0, 1'b0, 1'b0, 1'b0};
    endfunction

    function automatic ctrl_t imm_ctrl(alu_ctrl_e op);
        return '{1'b0, 1'b1, 1'b1, AOP_IMM, op, 1'b0, 1'b0, 1'b0, 1'b0};
    endfunction

    function automatic wb_t write_of(reg_idx_t addr, word_t data);
        return {1'b1, addr, data};
    endfunction

    // A same-cycle write is visible but r0 never is.
    function automatic word_t read_model(reg_idx_t idx, wb_t w);
        if (idx == 5'd0) begin
            return '0;
        end
        if (w.we && (w.addr == idx)) begin
            return w.data;
        end
        return shadow[idx];
    endfunction

    function automatic id_ex_t expected_id_ex(row_t r);
        id_ex_t  e;
        opcode_t op;
        imm16_t  imm;
        op         = r.instr[31:26];
        imm        = r.instr[15:0];
        e.ctrl     = r.ctrl;
        e.rs       = r.instr[25:21];
        e.rt       = r.instr[20:16];
        e.rd       = (op == OP_JAL) ? 5'd31 : r.instr[15:11];
        e.shamt    = r.instr[10:6];
        e.data_a   = read_model(e.rs, r.wb);
        e.data_b   = read_model(e.rt, r.wb);
        e.pc_plus1 = {{(32 - PC_W){1'b0}}, r.pc_plus1};
        if ((op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI)) begin
            e.ext_imm = {16'h0000, imm};
        end else begin
            e.ext_imm = {{16{imm[15]}}, imm};
        end
        return e;
    endfunction

    task automatic note_fail(string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(instr_t ins, logic [PC_W-1:0] pc, logic stl, logic fls, wb_t w,
                           ctrl_t c, logic tk, logic [PC_W-1:0] tgt);
        row_t r;
        r = '{ins, pc, stl, fls, w, c, tk, tgt};
        rows.push_back(r);
    endtask

    task automatic plain_case(instr_t ins, ctrl_t c);
        add_row(ins, PC_W'(rows.size() + 1), 1'b0, 1'b0, NO_WB, c, 1'b0, '0);
    endtask

    task automatic build_table();
        plain_case(r_format(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), rtype_ctrl(ALU_ADD));
        plain_case(r_format(5'd4, 5'd5, 5'd6, 5'd0, FN_SUBU), rtype_ctrl(ALU_SUB));
        plain_case(r_format(5'd7, 5'd8, 5'd9, 5'd0, FN_AND), rtype_ctrl(ALU_AND));
        plain_case(r_format(5'd10, 5'd11, 5'd12, 5'd0, FN_OR), rtype_ctrl(ALU_OR));
        plain_case(r_format(5'd13, 5'd14, 5'd15, 5'd0, FN_XOR), rtype_ctrl(ALU_XOR));
        plain_case(r_format(5'd16, 5'd17, 5'd18, 5'd0, FN_NOR), rtype_ctrl(ALU_NOR));
        plain_case(r_format(5'd19, 5'd20, 5'd21, 5'd0, FN_SLT), rtype_ctrl(ALU_SLT));
        plain_case(r_format(5'd0, 5'd22, 5'd23, 5'd5, FN_SLL), rtype_ctrl(ALU_SLL));
        plain_case(r_format(5'd0, 5'd24, 5'd25, 5'd31, FN_SRL), rtype_ctrl(ALU_SRL));
        plain_case(r_format(5'd0, 5'd26, 5'd27, 5'd1, FN_SRA), rtype_ctrl(ALU_SRA));
        // Immediates including negative ones.
        plain_case(i_format(OP_ADDIU, 5'd1, 5'd2, 16'hfff0), imm_ctrl(ALU_ADD));
        plain_case(i_format(OP_SLTI, 5'd3, 5'd4, 16'h8000), imm_ctrl(ALU_SLT));
        plain_case(i_format(OP_ANDI, 5'd5, 5'd6, 16'hff00), imm_ctrl(ALU_AND));
        plain_case(i_format(OP_ORI, 5'd7, 5'd8, 16'h8001), imm_ctrl(ALU_OR));
        plain_case(i_format(OP_XORI, 5'd9, 5'd10, 16'habcd), imm_ctrl(ALU_XOR));
        plain_case(i_format(OP_LUI, 5'd0, 5'd11, 16'h1234), imm_ctrl(ALU_LUI));
        plain_case(i_format(OP_LW, 5'd29, 5'd8, 16'hfffc), CTRL_LW);
        plain_case(i_format(OP_SW, 5'd29, 5'd9, 16'h0010), CTRL_SW);
        plain_case(i_format(6'h3f, 5'd1, 5'd2, 16'h0001), CTRL_NONE);
        plain_case(r_format(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), CTRL_NONE);
        // Write to r0 is dropped even on the bypass path.
        add_row(r_format(5'd0, 5'd0, 5'd1, 5'd0, FN_ADDU), 11'h040, 1'b0, 1'b0,
                write_of(5'd0, 32'hdead_beef), rtype_ctrl(ALU_ADD), 1'b0, 11'h000);
        plain_case(r_format(5'd0, 5'd2, 5'd1, 5'd0, FN_OR), rtype_ctrl(ALU_OR));
        // Register jumps with the target taken through the bypass.
        add_row(r_format(5'd5, 5'd0, 5'd0, 5'd0, FN_JR), 11'h050, 1'b0, 1'b0,
                write_of(5'd5, 32'h0000_0123), CTRL_NONE, 1'b1, 11'h123);
        add_row(r_format(5'd5, 5'd0, 5'd4, 5'd0, FN_JALR), 11'h051, 1'b0, 1'b0,
                NO_WB, CTRL_JALR, 1'b1, 11'h123);
        add_row(r_format(5'd2, 5'd2, 5'd3, 5'd0, FN_ADDU), 11'h060, 1'b0, 1'b0,
                write_of(5'd2, 32'h0000_0055), rtype_ctrl(ALU_ADD), 1'b0, 11'h000);
        // Conditional branches on r2 and r3.
        add_row(i_format(OP_BEQ, 5'd2, 5'd2, 16'h0004), 11'h100, 1'b0, 1'b0,
                write_of(5'd3, 32'h0000_0066), CTRL_NONE, 1'b1, 11'h104);
        add_row(i_format(OP_BEQ, 5'd2, 5'd3, 16'h0004), 11'h110, 1'b0, 1'b0,
                NO_WB, CTRL_NONE, 1'b0, 11'h000);
        add_row(i_format(OP_BNE, 5'd2, 5'd3, 16'hfff8), 11'h204, 1'b0, 1'b0,
                NO_WB, CTRL_NONE, 1'b1, 11'h1fc);
        add_row(i_format(OP_BNE, 5'd2, 5'd2, 16'h0010), 11'h210, 1'b0, 1'b0,
                NO_WB, CTRL_NONE, 1'b0, 11'h000);
        add_row(j_format(OP_J, 26'h3ff_f5a5), 11'h300, 1'b0, 1'b0,
                NO_WB, CTRL_NONE, 1'b1, 11'h5a5);
        add_row(j_format(OP_JAL, 26'h000_41ab), 11'h301, 1'b0, 1'b0,
                NO_WB, CTRL_JAL, 1'b1, 11'h1ab);
        // Stall and flush.
        add_row(i_format(OP_ORI, 5'd1, 5'd2, 16'h00ff), 11'h310, 1'b1, 1'b0,
                NO_WB, imm_ctrl(ALU_OR), 1'b0, 11'h000);
        add_row(i_format(OP_BEQ, 5'd2, 5'd2, 16'h0002), 11'h311, 1'b1, 1'b0,
                NO_WB, CTRL_NONE, 1'b1, 11'h313);
        plain_case(r_format(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), rtype_ctrl(ALU_ADD));
        add_row(r_format(5'd4, 5'd5, 5'd6, 5'd0, FN_SUBU), 11'h320, 1'b0, 1'b1,
                NO_WB, rtype_ctrl(ALU_SUB), 1'b0, 11'h000);
        plain_case(r_format(5'd13, 5'd14, 5'd15, 5'd0, FN_XOR), rtype_ctrl(ALU_XOR));
        add_row(i_format(OP_LW, 5'd29, 5'd8, 16'h0004), 11'h330, 1'b1, 1'b1,
                NO_WB, CTRL_LW, 1'b0, 11'h000);
        add_row(i_format(OP_SW, 5'd29, 5'd9, 16'h0008), 11'h331, 1'b1, 1'b0,
                NO_WB, CTRL_SW, 1'b0, 11'h000);
        plain_case(r_format(5'd7, 5'd8, 5'd9, 5'd0, FN_AND), rtype_ctrl(ALU_AND));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequences.
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        assert (id_ex === '0)
            else note_fail($sformatf("ID/EX %h after reset, expected zero", id_ex));
        instr = r_format(5'd7, 5'd9, 5'd1, 5'd0, FN_ADDU);
        @(negedge clock);
        assert ((id_ex.data_a === '0) && (id_ex.data_b === '0))
            else note_fail($sformatf("operands %h %h after reset, expected zero",
                                     id_ex.data_a, id_ex.data_b));
    endtask

    task automatic preload_registers();
        for (int r = 1; r < 32; r++) begin
            wb        = {1'b1, reg_idx_t'(r), word_t'($urandom)};
            shadow[r] = wb.data;
            @(negedge clock);
        end
        wb = '0;
    endtask

    task automatic check_id_ex(instr_t ins);
        assert (id_ex.ctrl === exp_q.ctrl)
            else note_fail($sformatf("instr %h ctrl %h, expected %h",
                                     ins, id_ex.ctrl, exp_q.ctrl));
        assert (id_ex.data_a === exp_q.data_a)
            else note_fail($sformatf("instr %h data_a %h, expected %h",
                                     ins, id_ex.data_a, exp_q.data_a));
        assert (id_ex.data_b === exp_q.data_b)
            else note_fail($sformatf("instr %h data_b %h, expected %h",
                                     ins, id_ex.data_b, exp_q.data_b));
        assert (id_ex.ext_imm === exp_q.ext_imm)
            else note_fail($sformatf("instr %h ext_imm %h, expected %h",
                                     ins, id_ex.ext_imm, exp_q.ext_imm));
        assert (id_ex === exp_q)
            else note_fail($sformatf("instr %h ID/EX %h, expected %h", ins, id_ex, exp_q));
    endtask

    // Called on a falling edge, returns on the next one.
    task automatic apply_row(row_t r);
        id_ex_t e;
        e        = expected_id_ex(r);
        instr    = r.instr;
        pc_plus1 = r.pc_plus1;
        stall    = r.stall;
        flush    = r.flush;
        wb       = r.wb;
        #(HALF_PERIOD - 1);
        assert (branch_taken === r.taken)
            else note_fail($sformatf("instr %h taken %b, expected %b",
                                     r.instr, branch_taken, r.taken));
        assert (branch_target === r.target)
            else note_fail($sformatf("instr %h target %h, expected %h",
                                     r.instr, branch_target, r.target));
        if (r.flush) begin
            exp_q = '0;
        end else if (!r.stall) begin
            exp_q = e;
        end
        if (r.wb.we && (r.wb.addr != 5'd0)) begin
            shadow[r.wb.addr] = r.wb.data;
        end
        @(negedge clock);
        check_id_ex(r.instr);
    endtask

    initial begin
        void'($urandom(32'h0fd9_c440));
        errors   = 0;
        arst_n   = 1'b0;
        instr    = '0;
        pc_plus1 = '0;
        wb       = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        exp_q    = '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        build_table();
        cycle_limit = 4 + 32 + 2 * rows.size() + 50;

        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_reset_state();
        preload_registers();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/id_stage_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage_chk
    import mips_ctrl_pkg::*;
#(
    parameter int PC_W = 11
)
(
    input wire            i_clock,
    input wire            i_arst_n,
    input wire            i_stall,
    input wire            i_flush,
    input wire id_ex_t    i_id_ex,
    input wire            i_branch_taken,
    input wire [PC_W-1:0] i_branch_target
);

    // First edge after reset still sees the bubble.
    assert property (@(posedge i_clock) $rose(i_arst_n) |-> (i_id_ex.ctrl == '0))
        else $error("ID/EX ctrl is not zero right after reset");

    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_flush |=> (i_id_ex.ctrl == '0))
        else $error("ID/EX ctrl is not zero after a flush");

    // Flush overrides stall, so only a plain stall must hold.
    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_stall && !i_flush) |=> $stable(i_id_ex))
        else $error("ID/EX register changed during a stall");

    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_branch_taken |-> !$isunknown(i_branch_target))
        else $error("branch target has unknown bits while taken");

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
#(
    parameter int PC_W = 11
)
(
    input  wire              i_clock,
    input  wire              i_arst_n,
    input  wire instr_t      i_instr,
    input  wire [PC_W-1:0]   i_pc_plus1,
    input  wire wb_t         i_wb,
    input  wire              i_stall,
    input  wire              i_flush,
    output id_ex_t           o_id_ex,
    output logic             o_branch_taken,
    output logic [PC_W-1:0]  o_branch_target
);

    localparam id_ex_t BUBBLE = '0;

    fields_t fields;
    word_t   data_a;
    word_t   data_b;
    ctrl_t   ctrl;
    opcode_t opcode;
    funct_t  funct;
    id_ex_t  id_ex_next;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];

    id_field_decoder u_field_decoder (
        .i_instr  (i_instr),
        .o_fields (fields)
    );

    id_register_file u_register_file (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_rs     (fields.rs),
        .i_rt     (fields.rt),
        .i_wb     (i_wb),
        .o_data_a (data_a),
        .o_data_b (data_b)
    );

    id_branch_unit #(
        .PC_W (PC_W)
    ) u_branch_unit (
        .i_fields   (fields),
        .i_data_a   (data_a),
        .i_data_b   (data_b),
        .i_pc_plus1 (i_pc_plus1),
        .o_taken    (o_branch_taken),
        .o_target   (o_branch_target)
    );

    id_control_unit u_control_unit (
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (ctrl)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        id_ex_next.ctrl     = ctrl;
        id_ex_next.data_a   = data_a;
        id_ex_next.data_b   = data_b;
        id_ex_next.ext_imm  = fields.ext_imm;
        id_ex_next.rs       = fields.rs;
        id_ex_next.rt       = fields.rt;
        // JAL links into r31.
        id_ex_next.rd       = (fields.branch_kind == BR_JAL) ? RA_IDX : fields.rd;
        id_ex_next.shamt    = fields.shamt;
        id_ex_next.pc_plus1 = {{(32 - PC_W){1'b0}}, i_pc_plus1};
    end

    // Flush wins over stall.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= BUBBLE;
        end else if (i_flush) begin
            o_id_ex <= BUBBLE;
        end else if (!i_stall) begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/id_control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_control_unit
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  wire opcode_t i_opcode,
    input  wire funct_t  i_funct,
    output ctrl_t        o_ctrl
);

    ctrl_t     main_ctrl;
    alu_ctrl_e alu_ctrl;

    ////////////////////////////////////////////////////////////////////////////
    // Main decoder.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        main_ctrl = '0;
        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLL, FN_SRL, FN_SRA: begin
                        main_ctrl.reg_dst   = 1'b1;
                        main_ctrl.reg_write = 1'b1;
                        main_ctrl.alu_op    = AOP_RTYPE;
                    end
                    FN_JALR: begin
                        main_ctrl.reg_dst   = 1'b1;
                        main_ctrl.reg_write = 1'b1;
                        main_ctrl.link      = 1'b1;
                    end
                    // JR and unknown funct codes stay a bubble.
                    default: main_ctrl = '0;
                endcase
            end
            OP_LW: begin
                main_ctrl.alu_src    = 1'b1;
                main_ctrl.mem_read   = 1'b1;
                main_ctrl.mem_to_reg = 1'b1;
                main_ctrl.reg_write  = 1'b1;
                main_ctrl.alu_op     = AOP_MEM_ADD;
            end
            OP_SW: begin
                main_ctrl.alu_src   = 1'b1;
                main_ctrl.mem_write = 1'b1;
                main_ctrl.alu_op    = AOP_MEM_ADD;
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                main_ctrl.alu_src   = 1'b1;
                main_ctrl.reg_write = 1'b1;
                main_ctrl.alu_op    = AOP_IMM;
            end
            OP_JAL: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.link      = 1'b1;
            end
            // Branches and J are resolved here and need nothing downstream.
            default: main_ctrl = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU control decoder.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_ctrl = ALU_ADD;
        case (main_ctrl.alu_op)
            AOP_MEM_ADD:    alu_ctrl = ALU_ADD;
            AOP_RTYPE: begin
                case (i_funct)
                    FN_SUBU: alu_ctrl = ALU_SUB;
                    FN_AND:  alu_ctrl = ALU_AND;
                    FN_OR:   alu_ctrl = ALU_OR;
                    FN_XOR:  alu_ctrl = ALU_XOR;
                    FN_NOR:  alu_ctrl = ALU_NOR;
                    FN_SLT:  alu_ctrl = ALU_SLT;
                    FN_SLL:  alu_ctrl = ALU_SLL;
                    FN_SRL:  alu_ctrl = ALU_SRL;
                    FN_SRA:  alu_ctrl = ALU_SRA;
                    default: alu_ctrl = ALU_ADD;
                endcase
            end
            AOP_IMM: begin
                case (i_opcode)
                    OP_SLTI: alu_ctrl = ALU_SLT;
                    OP_ANDI: alu_ctrl = ALU_AND;
                    OP_ORI:  alu_ctrl = ALU_OR;
                    OP_XORI: alu_ctrl = ALU_XOR;
                    OP_LUI:  alu_ctrl = ALU_LUI;
                    default: alu_ctrl = ALU_ADD;
                endcase
            end
            default: alu_ctrl = ALU_ADD;
        endcase
    end

    always_comb begin
        o_ctrl          = main_ctrl;
        o_ctrl.alu_ctrl = alu_ctrl;
    end

endmodule

`default_nettype wire

// ==== rtl/id_branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_branch_unit
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
#(
    parameter int PC_W = 11
)
(
    input  wire fields_t          i_fields,
    input  wire word_t            i_data_a,
    input  wire word_t            i_data_b,
    input  wire [PC_W-1:0]        i_pc_plus1,
    output logic                  o_taken,
    output logic [PC_W-1:0]       o_target
);

    logic            operands_eq;
    logic [PC_W-1:0] rel_target;

    assign operands_eq = (i_data_a == i_data_b);

    // Word-addressed, so the offset is added without a shift.
    assign rel_target = i_pc_plus1 + i_fields.ext_imm[PC_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Resolve taken flag and target.
    ////////////////////////////////////////////////////////////////////////////

    // Target is zero whenever the branch is not taken.
    always_comb begin
        o_taken  = 1'b0;
        o_target = '0;
        case (i_fields.branch_kind)
            BR_BEQ: begin
                if (operands_eq) begin
                    o_taken  = 1'b1;
                    o_target = rel_target;
                end
            end
            BR_BNE: begin
                if (!operands_eq) begin
                    o_taken  = 1'b1;
                    o_target = rel_target;
                end
            end
            BR_J, BR_JAL: begin
                o_taken  = 1'b1;
                o_target = i_fields.jidx[PC_W-1:0];
            end
            BR_JR, BR_JALR: begin
                o_taken  = 1'b1;
                o_target = i_data_a[PC_W-1:0];
            end
            default: begin
                o_taken  = 1'b0;
                o_target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/id_register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_register_file
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  wire         i_clock,
    input  wire         i_arst_n,
    input  wire reg_idx_t i_rs,
    input  wire reg_idx_t i_rt,
    input  wire wb_t    i_wb,
    output word_t       o_data_a,
    output word_t       o_data_b
);

    word_t rf [32];
    logic  wr_en;

    // Index 0 is hardwired to zero.
    assign wr_en = i_wb.we && (i_wb.addr != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rf <= '{default: '0};
        end else if (wr_en) begin
            rf[i_wb.addr] <= i_wb.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports with write-through bypass.
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t read_port(
        input reg_idx_t idx,
        input wb_t      wb,
        input word_t    stored
    );
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.we && (wb.addr == idx)) begin
            value = wb.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    assign o_data_a = read_port(i_rs, i_wb, rf[i_rs]);
    assign o_data_b = read_port(i_rt, i_wb, rf[i_rt]);

endmodule

`default_nettype wire

// ==== rtl/id_field_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_field_decoder
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  wire instr_t  i_instr,
    output fields_t      o_fields
);

    opcode_t opcode;
    funct_t  funct;
    imm16_t  imm;
    logic    zero_ext;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign imm    = i_instr[15:0];

    // Logical immediates are unsigned.
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

    always_comb begin
        o_fields.rs    = i_instr[25:21];
        o_fields.rt    = i_instr[20:16];
        o_fields.rd    = i_instr[15:11];
        o_fields.shamt = i_instr[10:6];
        o_fields.jidx  = i_instr[25:0];

        if (zero_ext) begin
            o_fields.ext_imm = {16'h0000, imm};
        end else begin
            o_fields.ext_imm = {{16{imm[15]}}, imm};
        end

        o_fields.branch_kind = BR_NONE;
        case (opcode)
            OP_BEQ:   o_fields.branch_kind = BR_BEQ;
            OP_BNE:   o_fields.branch_kind = BR_BNE;
            OP_J:     o_fields.branch_kind = BR_J;
            OP_JAL:   o_fields.branch_kind = BR_JAL;
            OP_RTYPE: begin
                // Register jumps live in the funct field.
                if (funct == FN_JR) begin
                    o_fields.branch_kind = BR_JR;
                end else if (funct == FN_JALR) begin
                    o_fields.branch_kind = BR_JALR;
                end
            end
            default:  o_fields.branch_kind = BR_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mips_ctrl_pkg.sv ====
`default_nettype none

package mips_ctrl_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        AOP_MEM_ADD    = 2'd0,
        AOP_BRANCH_SUB = 2'd1,
        AOP_RTYPE      = 2'd2,
        AOP_IMM        = 2'd3
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_J    = 3'd3,
        BR_JAL  = 3'd4,
        BR_JR   = 3'd5,
        BR_JALR = 3'd6
    } branch_kind_e;

    // All zero is a bubble.
    typedef struct packed {
        logic      reg_dst;
        logic      reg_write;
        logic      alu_src;
        alu_op_e   alu_op;
        alu_ctrl_e alu_ctrl;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      link;
    } ctrl_t;

    // Write-back request.
    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } wb_t;

    typedef struct packed {
        reg_idx_t     rs;
        reg_idx_t     rt;
        reg_idx_t     rd;
        shamt_t       shamt;
        word_t        ext_imm;
        jidx_t        jidx;
        branch_kind_e branch_kind;
    } fields_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    data_a;
        word_t    data_b;
        word_t    ext_imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   shamt;
        word_t    pc_plus1;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== rtl/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word fields.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jidx_t;
    typedef logic [31:0] word_t;

    // Link register for JAL.
    localparam reg_idx_t RA_IDX = 5'd31;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes.
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    ////////////////////////////////////////////////////////////////////////////
    // R-type function codes.
    ////////////////////////////////////////////////////////////////////////////

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

`default_nettype wire
